//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_periph_hub -o sim_tb \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"

//--- sim/tb_clock.sv
// Testbench clock and reset generator
// 20 ns clock, synchronous reset held low for the first rising edges

`default_nettype none

module tb_clock #(
    parameter int reset_cycles = 5
) (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    // Release lands after the edge, in step with the other inputs
    initial begin
        o_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge o_clk);
        #2;
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_periph_hub.sv
// Peripheral hub testbench
// Random reads and writes against a model of the GPIO register,
// function selects and byte slots, with read handshake timing checks

`default_nettype none

module tb_periph_hub;
    timeunit 1ns;
    timeprecision 1ps;

    import periph_pkg::*;

    localparam int SEED           = 8034;
    localparam int NUM_TRANS      = 400;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int NUM_PINS       = $bits(pins_t);

    logic       clk;
    logic       rst_n;
    pins_t      ui_in;
    pins_t      uo_out;
    addr_t      addr;
    bus_word_t  data_in;
    size_code_t data_write_n;
    size_code_t data_read_n;
    bus_word_t  data_out;
    logic       data_ready;
    logic       data_read_complete;

    // Model state
    pins_t      gpio_out_m;
    func_sel_t  func_sel_m [NUM_PINS];
    byte_t      slot_out_m [NUM_SLOTS];
    byte_t      slot_scr_m [NUM_SLOTS];
    logic [31:0] lcg_state;

    tb_clock #(.reset_cycles(5)) clk_gen_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    periph_hub_top #(.num_slots(NUM_SLOTS)) dut_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (data_write_n),
        .i_data_read_n        (data_read_n),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .i_data_read_complete (data_read_complete)
    );

    function automatic int next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'({16'd0, lcg_state[31:16]});
    endfunction

    // Biased toward mapped registers with some fully random addresses
    function automatic addr_t pick_addr();
        int kind;
        int r;
        addr_t a;
        kind = next_random() % 4;
        r = next_random();
        case (kind)
            0: a = (r % 2 == 0) ? GPIO_OUT_ADDR : GPIO_IN_ADDR;
            1: a = FUNC_SEL_BASE + addr_t'(4 * (r % 8));
            2: a = {1'b1, 3'(r % 8), 4'((r / 8) % 4)};
            default: a = addr_t'(r);
        endcase
        return a;
    endfunction

    function automatic logic is_func_sel(input addr_t a);
        return (a >= FUNC_SEL_BASE) && (a < FUNC_SEL_BASE + 8'd32) && (a[1:0] == 2'b00);
    endfunction

    function automatic bus_word_t expected_read(input addr_t a);
        bus_word_t v;
        v = '0;
        if (a[BYTE_REGION_BIT]) begin
            case (a[3:0])
                4'h0: v = bus_word_t'(slot_out_m[a[6:4]]);
                4'h1: v = bus_word_t'(slot_scr_m[a[6:4]]);
                4'h2: v = bus_word_t'(ui_in);
                default: v = '0;
            endcase
        end else if (a == GPIO_OUT_ADDR) begin
            v = bus_word_t'(gpio_out_m);
        end else if (a == GPIO_IN_ADDR) begin
            v = bus_word_t'(ui_in);
        end else if (is_func_sel(a)) begin
            v = bus_word_t'(func_sel_m[3'((a - FUNC_SEL_BASE) >> 2)]);
        end
        return v;
    endfunction

    function automatic pins_t expected_pins();
        pins_t p;
        for (int n = 0; n < NUM_PINS; n++) begin
            if (func_sel_m[n][3]) begin
                p[n] = slot_out_m[func_sel_m[n][2:0]][n];
            end else begin
                p[n] = gpio_out_m[n];
            end
        end
        return p;
    endfunction

    task automatic model_write(input addr_t a, input byte_t b);
        if (a[BYTE_REGION_BIT]) begin
            if (a[3:0] == 4'h0) begin
                slot_out_m[a[6:4]] = b;
            end else if (a[3:0] == 4'h1) begin
                slot_scr_m[a[6:4]] = b;
            end
        end else if (a == GPIO_OUT_ADDR) begin
            gpio_out_m = b;
        end else if (is_func_sel(a)) begin
            func_sel_m[3'((a - FUNC_SEL_BASE) >> 2)] = b[3:0];
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input bus_word_t got, input bus_word_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_pins(input pins_t got, input pins_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (rst_n !== 1'b1 && cycles >= TIMEOUT_CYCLES) begin
                fail_run("reset was never released");
            end
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic write_access(input addr_t a, input bus_word_t d);
        addr = a;
        data_in = d;
        data_write_n = size_code_t'(next_random() % 3);
        data_read_n = SIZE_IDLE;
        #1;
        check_flag(data_ready, 1'b1, "write acknowledge");
        @(posedge clk);
        model_write(a, d[7:0]);
        #2;
        data_write_n = SIZE_IDLE;
    endtask

    task automatic read_access(input addr_t a);
        bus_word_t exp;
        bus_word_t held;
        int cycles;
        int delay;
        logic got_ready;
        addr = a;
        data_read_n = size_code_t'(next_random() % 3);
        data_write_n = SIZE_IDLE;
        exp = expected_read(a);
        #1;
        check_flag(data_ready, 1'b0, "ready in request cycle");
        cycles = 0;
        got_ready = 1'b0;
        while (!got_ready) begin
            @(posedge clk);
            #1;
            cycles++;
            got_ready = data_ready;
            if (!got_ready && cycles >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("read at %h timed out, o_data_ready never came", a));
            end
        end
        if (cycles != 1) begin
            fail_run($sformatf("mismatch at %0t: read ready after %0d cycles", $time, cycles));
        end
        check_word(data_out, exp, $sformatf("read data at %h", a));
        held = data_out;
        // Core stalls the complete while the inputs keep moving
        delay = next_random() % 4;
        repeat (delay) begin
            #1;
            ui_in = pins_t'(next_random());
            @(posedge clk);
            #1;
            check_word(data_out, held, "held read data");
        end
        #1;
        data_read_n = SIZE_IDLE;
        data_read_complete = 1'b1;
        @(posedge clk);
        #2;
        data_read_complete = 1'b0;
    endtask

    initial begin
        ui_in = '0;
        addr = '0;
        data_in = '0;
        data_write_n = SIZE_IDLE;
        data_read_n = SIZE_IDLE;
        data_read_complete = 1'b0;
        lcg_state = 32'(SEED);
        gpio_out_m = '0;
        for (int n = 0; n < NUM_PINS; n++) begin
            func_sel_m[n] = '0;
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            slot_out_m[s] = '0;
            slot_scr_m[s] = '0;
        end

        wait_reset_release();
        @(posedge clk);
        #2;

        // Reset state
        check_pins(uo_out, '0, "pins after reset");
        read_access(GPIO_OUT_ADDR);
        for (int n = 0; n < NUM_PINS; n++) begin
            read_access(FUNC_SEL_BASE + addr_t'(4 * n));
        end

        for (int i = 0; i < NUM_TRANS; i++) begin
            if (next_random() % 4 == 0) begin
                ui_in = pins_t'(next_random());
            end
            if (next_random() % 2 == 0) begin
                write_access(pick_addr(), {16'(next_random()), 16'(next_random())});
            end else begin
                read_access(pick_addr());
            end
            check_pins(uo_out, expected_pins(), "output pins");
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/bus_decode.sv
// Address decoder
// Splits the core address into region, slot and offset, and turns a
// write request into one strobe for a byte slot or for the GPIO block

`default_nettype none

module bus_decode #(
    parameter int num_slots = periph_pkg::NUM_SLOTS
) (
    input  wire periph_pkg::addr_t       i_addr,
    input  wire periph_pkg::bus_word_t   i_data_in,
    input  wire periph_pkg::size_code_t  i_data_write_n,
    periph_bus_if.decoder                bus,
    output logic                         o_in_byte_region,
    output logic [$clog2(num_slots)-1:0] o_slot,
    output logic                         o_gpio_wr
);
    import periph_pkg::*;

    localparam int slot_w = $clog2(num_slots);
    // Slot index sits directly above the register offset
    localparam int slot_lsb = $bits(offset_t);

    logic write_req;

    // Write size does not matter, every target keeps only the low byte
    assign write_req = (i_data_write_n != SIZE_IDLE);

    assign o_in_byte_region = i_addr[BYTE_REGION_BIT];
    assign o_slot = i_addr[slot_lsb +: slot_w];
    assign o_gpio_wr = write_req && !o_in_byte_region;

    assign bus.offset = i_addr[slot_lsb-1:0];
    assign bus.wdata = i_data_in[$bits(byte_t)-1:0];

    // One-hot slot strobe, only in the byte region
    always_comb begin
        bus.wr_sel = '0;
        if (write_req && o_in_byte_region) begin
            bus.wr_sel[o_slot] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/byte_periph.sv
// Generic byte peripheral
// Output register driving the slot's pins, one scratch register,
// and readback of both plus the input pins

`default_nettype none

module byte_periph #(
    parameter int slot_index = 0
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire periph_pkg::pins_t i_pins_in,
    periph_bus_if.slot             bus
);
    import periph_pkg::*;

    byte_t out_reg;
    byte_t scratch_reg;
    byte_t rd_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_reg     <= '0;
            scratch_reg <= '0;
        end else if (bus.wr_sel[slot_index]) begin
            case (bus.offset)
                4'h0: out_reg <= bus.wdata;
                4'h1: scratch_reg <= bus.wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (bus.offset)
            4'h0:    rd_byte = out_reg;
            4'h1:    rd_byte = scratch_reg;
            4'h2:    rd_byte = i_pins_in;
            default: rd_byte = '0;
        endcase
    end

    assign bus.rdata[slot_index]   = rd_byte;
    assign bus.pin_out[slot_index] = out_reg;

endmodule

`default_nettype wire

//--- src/gpio_ctrl.sv
// GPIO controller
// Holds the GPIO output register and one function select per pin,
// returns their readback and routes each output pin to GPIO or a slot

`default_nettype none

module gpio_ctrl #(
    parameter int num_slots = periph_pkg::NUM_SLOTS
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire periph_pkg::addr_t     i_addr,
    input  wire periph_pkg::byte_t     i_wdata,
    input  wire logic                  i_gpio_wr,
    input  wire periph_pkg::pins_t     i_pins_in,
    periph_bus_if.drain                slots,
    output periph_pkg::bus_word_t      o_gpio_rdata,
    output periph_pkg::pins_t          o_uo_out
);
    import periph_pkg::*;

    localparam int slot_w   = $clog2(num_slots);
    localparam int num_pins = $bits(pins_t);
    localparam int pin_w    = $clog2(num_pins);
    localparam int sel_top  = $bits(func_sel_t) - 1;

    pins_t            gpio_out;
    func_sel_t        func_sel [num_pins];
    logic             out_hit;
    logic             in_hit;
    logic             sel_hit;
    logic [pin_w-1:0] sel_pin;

    assign out_hit = (i_addr == GPIO_OUT_ADDR);
    assign in_hit  = (i_addr == GPIO_IN_ADDR);

    // Word-spaced select registers in the block starting at FUNC_SEL_BASE
    assign sel_hit = (i_addr[7:5] == FUNC_SEL_BASE[7:5]) && (i_addr[1:0] == 2'b00);
    assign sel_pin = i_addr[2 +: pin_w];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int n = 0; n < num_pins; n++) begin
                func_sel[n] <= '0;
            end
        end else if (i_gpio_wr) begin
            if (out_hit) begin
                gpio_out <= i_wdata;
            end
            if (sel_hit) begin
                func_sel[sel_pin] <= i_wdata[sel_top:0];
            end
        end
    end

    always_comb begin
        if (out_hit) begin
            o_gpio_rdata = bus_word_t'(gpio_out);
        end else if (in_hit) begin
            o_gpio_rdata = bus_word_t'(i_pins_in);
        end else if (sel_hit) begin
            o_gpio_rdata = bus_word_t'(func_sel[sel_pin]);
        end else begin
            o_gpio_rdata = '0;
        end
    end

    // Per-pin source mux, a select naming a missing slot drives 0
    always_comb begin
        for (int n = 0; n < num_pins; n++) begin
            o_uo_out[n] = gpio_out[n];
            if (func_sel[n][sel_top]) begin
                o_uo_out[n] = 1'b0;
                if (int'(func_sel[n][sel_top-1:0]) < num_slots) begin
                    o_uo_out[n] = slots.pin_out[func_sel[n][slot_w-1:0]][n];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/periph_bus_if.sv
// Byte peripheral bus
// Carries decoded write traffic out to the slot array and brings
// each slot's read byte and pin outputs back to the hub

`default_nettype none

interface periph_bus_if #(
    parameter int num_slots = periph_pkg::NUM_SLOTS
);
    import periph_pkg::*;

    offset_t              offset;
    byte_t                wdata;
    logic [num_slots-1:0] wr_sel;

    // One entry per slot, each slot drives only its own
    byte_t                rdata   [num_slots];
    pins_t                pin_out [num_slots];

    modport decoder (output offset, output wdata, output wr_sel);

    modport slot (
        input  offset,
        input  wdata,
        input  wr_sel,
        output rdata,
        output pin_out
    );

    modport drain (input rdata, input pin_out);

endinterface

`default_nettype wire

//--- src/periph_hub_top.sv
// Peripheral hub top level
// Connects the core request ports to the address decoder, the byte
// slot array, the GPIO block and the registered read return

`default_nettype none

module periph_hub_top #(
    parameter int num_slots = periph_pkg::NUM_SLOTS
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire periph_pkg::pins_t      i_ui_in,
    output periph_pkg::pins_t           o_uo_out,
    input  wire periph_pkg::addr_t      i_addr,
    input  wire periph_pkg::bus_word_t  i_data_in,
    input  wire periph_pkg::size_code_t i_data_write_n,
    input  wire periph_pkg::size_code_t i_data_read_n,
    output periph_pkg::bus_word_t       o_data_out,
    output logic                        o_data_ready,
    input  wire logic                   i_data_read_complete
);
    import periph_pkg::*;

    localparam int slot_w = $clog2(num_slots);

    logic              in_byte_region;
    logic [slot_w-1:0] slot;
    logic              gpio_wr;
    bus_word_t         gpio_rdata;

    periph_bus_if #(.num_slots(num_slots)) bus_i ();

    bus_decode #(.num_slots(num_slots)) decode_i (
        .i_addr           (i_addr),
        .i_data_in        (i_data_in),
        .i_data_write_n   (i_data_write_n),
        .bus              (bus_i.decoder),
        .o_in_byte_region (in_byte_region),
        .o_slot           (slot),
        .o_gpio_wr        (gpio_wr)
    );

    for (genvar s = 0; s < num_slots; s++) begin : g_slot
        byte_periph #(.slot_index(s)) slot_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .i_pins_in (i_ui_in),
            .bus       (bus_i.slot)
        );
    end

    gpio_ctrl #(.num_slots(num_slots)) gpio_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_addr       (i_addr),
        .i_wdata      (bus_i.wdata),
        .i_gpio_wr    (gpio_wr),
        .i_pins_in    (i_ui_in),
        .slots        (bus_i.drain),
        .o_gpio_rdata (gpio_rdata),
        .o_uo_out     (o_uo_out)
    );

    read_return #(.num_slots(num_slots)) rret_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .i_in_byte_region     (in_byte_region),
        .i_slot               (slot),
        .i_gpio_rdata         (gpio_rdata),
        .slots                (bus_i.drain),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

endmodule

`default_nettype wire

//--- src/periph_pkg.sv
// Peripheral hub package
// Shared widths, types, address map and pin function-select encoding
// for the bus hub between the core and its peripherals

`default_nettype none

package periph_pkg;

    typedef logic [7:0]  addr_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  pins_t;
    typedef logic [3:0]  offset_t;
    typedef logic [1:0]  size_code_t;

    // Top bit set selects a byte slot (low bits), clear selects GPIO
    typedef logic [3:0]  func_sel_t;

    parameter int NUM_SLOTS = 8;

    // All ones on a size code means no access this cycle
    parameter size_code_t SIZE_IDLE = 2'b11;

    // Byte region carries slot in bits 6:4 and offset in bits 3:0
    parameter int BYTE_REGION_BIT = 7;

    parameter addr_t GPIO_OUT_ADDR = 8'h00;
    parameter addr_t GPIO_IN_ADDR  = 8'h04;

    // Pin n select register lives at FUNC_SEL_BASE + 4n
    parameter addr_t FUNC_SEL_BASE = 8'h20;

endpackage

`default_nettype wire

//--- src/read_return.sv
// Read return path
// Picks the slot byte or GPIO word, captures it once per read and
// holds it until the core signals read complete

`default_nettype none

module read_return #(
    parameter int num_slots = periph_pkg::NUM_SLOTS
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire periph_pkg::size_code_t       i_data_read_n,
    input  wire periph_pkg::size_code_t       i_data_write_n,
    input  wire logic                         i_data_read_complete,
    input  wire logic                         i_in_byte_region,
    input  wire logic [$clog2(num_slots)-1:0] i_slot,
    input  wire periph_pkg::bus_word_t        i_gpio_rdata,
    periph_bus_if.drain                       slots,
    output periph_pkg::bus_word_t             o_data_out,
    output logic                              o_data_ready
);
    import periph_pkg::*;

    logic      read_req;
    logic      write_req;
    bus_word_t read_sel;
    bus_word_t data_r;
    logic      hold;
    logic      ready_r;

    assign read_req  = (i_data_read_n != SIZE_IDLE);
    assign write_req = (i_data_write_n != SIZE_IDLE);

    assign read_sel = i_in_byte_region ? bus_word_t'(slots.rdata[i_slot]) : i_gpio_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold <= 1'b0;
            end
            // A new capture wins over a same-cycle complete
            if (read_req && !hold) begin
                hold <= 1'b1;
            end
            ready_r <= read_req;
        end
    end

    // Payload only, loaded on the first cycle of a read
    always_ff @(posedge clk) begin
        if (read_req && !hold) begin
            data_r <= read_sel;
        end
    end

    assign o_data_out = data_r;

    // Writes are acknowledged in their own cycle
    assign o_data_ready = ready_r || write_req;

endmodule

`default_nettype wire

//--- verilog.f
src/periph_pkg.sv
src/periph_bus_if.sv
src/bus_decode.sv
src/byte_periph.sv
src/gpio_ctrl.sv
src/read_return.sv
src/periph_hub_top.sv
sim/tb_clock.sv
sim/tb_periph_hub.sv
